// ==== project.f ====
+incdir+common
common/ipc_host_pkg.sv
common/ipc_queue_pkg.sv
logic/host_reg_handler.sv
logic/input_queue.sv
logic/msg_dispatch_fsm.sv
logic/h2f_ipc_core.sv
dv/tb_engine_models.sv
dv/tb_h2f_ipc_core.sv

// ==== Makefile ====
TOP = tb_h2f_ipc_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f \
		--Mdir obj_dir -o sim_$(TOP)

# Pass only when the log holds the pass line
run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_h2f_ipc_core.sv ====
`timescale 1ns/10ps

`include "ipc_macros.svh"

module tb_h2f_ipc_core
    import ipc_host_pkg::*;
    import ipc_queue_pkg::*;
;

    localparam int OP_READ  = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_HOLD  = 2;
    localparam int OP_DRAIN = 3;
    localparam int DRAIN_TIMEOUT = 2000;

    // Register byte addresses, index times four
    localparam reg_data_t A_WADDR_H = 32'h0000_0000;
    localparam reg_data_t A_WADDR_L = 32'h0000_0004;
    localparam reg_data_t A_WRITE   = 32'h0000_0008;

    logic      clk;
    logic      resetn;
    reg_data_t reg_raddr;
    logic      reg_read;
    reg_data_t reg_rdata;
    resp_t     reg_rresp;
    reg_data_t reg_waddr;
    logic      reg_write;
    resp_t     reg_wresp;
    addr_t     tok_str_addr;
    logic      tok_start;
    logic      tok_idle;
    logic      dispatcher_start;
    logic      dispatcher_idle;
    logic      hold;

    // Stimulus table, one entry per index
    int        op_q[$];
    reg_data_t addr_q[$];
    reg_data_t data_q[$];
    resp_t     resp_q[$];
    string     name_q[$];

    // Slot addresses expected on tok_str_addr, in dispatch order
    addr_t     exp_tok_q[$];
    int        build_idx = 0;
    int        push_cnt = 0;
    int        tok_seen = 0;
    int        disp_seen = 0;
    logic      disp_pending = 1'b0;
    int        value_errs = 0;
    int        proto_errs = 0;
    logic      timed_out = 1'b0;

    h2f_ipc_core DUT (.*);

    tb_engine_models u_engines (
        .clk              (clk),
        .resetn           (resetn),
        .hold             (hold),
        .tok_start        (tok_start),
        .tok_idle         (tok_idle),
        .dispatcher_start (dispatcher_start),
        .dispatcher_idle  (dispatcher_idle)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Slot n sits n slot sizes above the RAM start, modulo the depth
    function automatic addr_t slot_base(input int n);
        return addr_t'(`IPC_RAM_START) + addr_t'(n % `IPC_Q_SIZE) * addr_t'(`IPC_STR_MAXLEN);
    endfunction

    //======================================================================
    // Table building
    //======================================================================
    task automatic add_op(input int op, input reg_data_t addr, input reg_data_t data,
                          input resp_t resp, input string name);
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        resp_q.push_back(resp);
        name_q.push_back(name);
    endtask

    // Both halves of the next free slot
    task automatic add_latch(input string name);
        addr_t slot;
        slot = slot_base(build_idx);
        add_op(OP_READ, A_WADDR_H, slot[63:32], OKAY, {name, " latch_h"});
        add_op(OP_READ, A_WADDR_L, slot[31:0], OKAY, {name, " latch_l"});
    endtask

    task automatic add_doorbell(input string name);
        add_op(OP_WRITE, A_WRITE, '0, OKAY, {name, " doorbell"});
        exp_tok_q.push_back(slot_base(build_idx));
        build_idx++;
    endtask

    task automatic build_table();
        addr_t slot;
        // Register decode and doorbell rules
        add_op(OP_WRITE, A_WRITE, '0, SLVERR, "doorbell before latch");
        add_latch("reset");
        add_doorbell("first");
        add_op(OP_WRITE, A_WRITE, '0, SLVERR, "second doorbell");
        add_op(OP_READ, A_WRITE, '0, DECERR, "read doorbell reg");
        add_op(OP_READ, 32'h0000_000C, '0, DECERR, "read index 3");
        add_op(OP_READ, 32'h0000_007C, '0, DECERR, "read index 31");
        add_op(OP_WRITE, A_WADDR_H, '0, DECERR, "write latch_h reg");
        add_op(OP_DRAIN, '0, '0, OKAY, "first drain");
        // In-order dispatch across the wrap
        for (int m = 0; m < 20; m++) begin
            add_latch("order");
            add_doorbell("order");
            if (m % 4 == 3) begin
                add_op(OP_DRAIN, '0, '0, OKAY, "order drain");
            end
        end
        // Back-pressure, engines stalled until the queue is full
        add_op(OP_HOLD, 32'd1, '0, OKAY, "hold on");
        for (int m = 0; m < `IPC_Q_SIZE; m++) begin
            add_latch("fill");
            add_doorbell("fill");
        end
        add_op(OP_READ, A_WADDR_H, 32'hFFFF_FFFF, OKAY, "full latch_h");
        add_op(OP_READ, A_WADDR_L, 32'hFFFF_FFFF, OKAY, "full latch_l");
        add_op(OP_WRITE, A_WRITE, '0, SLVERR, "full doorbell");
        add_op(OP_HOLD, 32'd0, '0, OKAY, "hold off");
        add_op(OP_DRAIN, '0, '0, OKAY, "full drain");
        // Latch still reads empty after the pops freed slots
        add_op(OP_READ, A_WADDR_L, 32'hFFFF_FFFF, OKAY, "kept empty latch_l");
        add_latch("refill");
        add_doorbell("refill");
        add_op(OP_DRAIN, '0, '0, OKAY, "refill drain");
        // A pop between the two halves leaves the latched value alone
        add_op(OP_HOLD, 32'd1, '0, OKAY, "hold on");
        add_latch("split");
        add_doorbell("split");
        slot = slot_base(build_idx);
        add_op(OP_READ, A_WADDR_H, slot[63:32], OKAY, "split latch_h");
        add_op(OP_HOLD, 32'd0, '0, OKAY, "hold off");
        add_op(OP_DRAIN, '0, '0, OKAY, "split drain");
        add_op(OP_READ, A_WADDR_L, slot[31:0], OKAY, "split latch_l");
        add_doorbell("split last");
        add_op(OP_DRAIN, '0, '0, OKAY, "final drain");
    endtask

    //======================================================================
    // Table application
    //======================================================================
    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act != exp) begin
            $display("[ERROR] %s resp: expected %0d, actual %0d", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic wait_drain(input string name);
        int waited;
        waited = 0;
        while (!(tok_seen == push_cnt && disp_seen == push_cnt && tok_idle && dispatcher_idle)
               && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= DRAIN_TIMEOUT) begin
            $display("%s: queue did not drain within %0d cycles", name, DRAIN_TIMEOUT);
            proto_errs++;
            timed_out = 1'b1;
        end else begin
            // Pop lands on the edge after the dispatcher goes idle
            @(negedge clk);
            @(negedge clk);
        end
    endtask

    task automatic apply_op(input int i);
        case (op_q[i])
            OP_READ: begin
                @(negedge clk);
                reg_raddr = addr_q[i];
                reg_read  = 1'b1;
                @(negedge clk);
                reg_read  = 1'b0;
                check_resp(name_q[i], resp_q[i], reg_rresp);
                if (resp_q[i] == OKAY && reg_rdata != data_q[i]) begin
                    $display("[ERROR] %s data: expected %h, actual %h",
                             name_q[i], data_q[i], reg_rdata);
                    value_errs++;
                end
            end
            OP_WRITE: begin
                @(negedge clk);
                reg_waddr = addr_q[i];
                reg_write = 1'b1;
                @(negedge clk);
                reg_write = 1'b0;
                check_resp(name_q[i], resp_q[i], reg_wresp);
                if (resp_q[i] == OKAY) begin
                    push_cnt++;
                end
            end
            OP_HOLD: begin
                @(negedge clk);
                hold = addr_q[i][0];
            end
            default: wait_drain(name_q[i]);
        endcase
    endtask

    //======================================================================
    // Dispatch monitor, one dispatcher start per tokenizer start
    //======================================================================
    always @(posedge clk) begin : dispatch_monitor
        addr_t exp_addr;
        if (resetn) begin
            if (tok_start) begin
                if (exp_tok_q.size() == 0 || tok_seen >= push_cnt) begin
                    $display("tok_start seen with no accepted doorbell pending");
                    proto_errs++;
                end else begin
                    exp_addr = exp_tok_q.pop_front();
                    if (tok_str_addr != exp_addr) begin
                        $display("[ERROR] dispatch order msg %0d: expected %h, actual %h",
                                 tok_seen, exp_addr, tok_str_addr);
                        value_errs++;
                    end
                end
                if (disp_pending) begin
                    $display("tok_start before the previous message reached the dispatcher");
                    proto_errs++;
                end
                disp_pending = 1'b1;
                tok_seen++;
            end
            if (dispatcher_start) begin
                if (!disp_pending) begin
                    $display("dispatcher_start with no tokenized message");
                    proto_errs++;
                end
                disp_pending = 1'b0;
                disp_seen++;
            end
        end
    end

    initial begin : main
        int i;
        resetn    = 1'b0;
        reg_raddr = '0;
        reg_read  = 1'b0;
        reg_waddr = '0;
        reg_write = 1'b0;
        hold      = 1'b0;
        build_table();
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        if (tok_start || dispatcher_start) begin
            $display("Start pulses high after reset");
            proto_errs++;
        end
        for (i = 0; i < op_q.size(); i++) begin
            if (timed_out) begin
                break;
            end
            apply_op(i);
        end
        if (!timed_out && exp_tok_q.size() != 0) begin
            $display("%0d accepted messages never reached the tokenizer", exp_tok_q.size());
            proto_errs++;
        end
        $display("Summary: %0d value errors, %0d protocol errors, %0d messages dispatched",
                 value_errs, proto_errs, disp_seen);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== dv/tb_engine_models.sv ====
`timescale 1ns/10ps

// Behavioral tokenizer and dispatcher with random busy times
module tb_engine_models (
    input  logic clk,
    input  logic resetn,

    // Forces both engines to report busy
    input  logic hold,

    input  logic tok_start,
    output logic tok_idle,
    input  logic dispatcher_start,
    output logic dispatcher_idle
);

    logic [31:0] lfsr;
    logic [3:0]  tok_cnt;
    logic [3:0]  disp_cnt;

    // One Galois LFSR step, the bit taken is the old lsb
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hB4BC_D35C;
        end
        return s >> 1;
    endfunction

    // Busy time of 1 to 8 cycles, three LFSR bits per draw
    task automatic draw_busy(output logic [3:0] cycles);
        logic [2:0] raw;
        for (int b = 0; b < 3; b++) begin
            raw[b] = lfsr[0];
            lfsr   = galois_step(lfsr);
        end
        cycles = {1'b0, raw} + 4'd1;
    endtask

    //======================================================================
    // Busy counters, loaded on each start pulse
    //======================================================================
    always @(posedge clk) begin : busy_seq
        logic [3:0] cycles;
        if (!resetn) begin
            lfsr     = 32'h689f4bd6;
            tok_cnt  <= '0;
            disp_cnt <= '0;
        end else begin
            if (tok_start) begin
                draw_busy(cycles);
                tok_cnt <= cycles;
            end else if (tok_cnt != 4'd0) begin
                tok_cnt <= tok_cnt - 1'b1;
            end
            if (dispatcher_start) begin
                draw_busy(cycles);
                disp_cnt <= cycles;
            end else if (disp_cnt != 4'd0) begin
                disp_cnt <= disp_cnt - 1'b1;
            end
        end
    end

    // Idle drops in the same cycle as the start pulse
    assign tok_idle        = (tok_cnt == 4'd0) && !tok_start && !hold;
    assign dispatcher_idle = (disp_cnt == 4'd0) && !dispatcher_start && !hold;

endmodule

// ==== logic/h2f_ipc_core.sv ====
`timescale 1ns/10ps

module h2f_ipc_core
    import ipc_host_pkg::*;
    import ipc_queue_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,

    // Host register port
    input  reg_data_t reg_raddr,
    input  logic      reg_read,
    output reg_data_t reg_rdata,
    output resp_t     reg_rresp,
    input  reg_data_t reg_waddr,
    input  logic      reg_write,
    output resp_t     reg_wresp,

    // External tokenizer
    output addr_t     tok_str_addr,
    output logic      tok_start,
    input  logic      tok_idle,

    // Downstream dispatcher
    output logic      dispatcher_start,
    input  logic      dispatcher_idle
);

    // Queue handshake between the three blocks
    logic  q_push;
    logic  q_pop;
    logic  q_not_empty;
    addr_t next_slot_addr;
    addr_t head_addr;

    //======================================================================
    // Host side, hands out slots and accepts doorbells
    //======================================================================
    host_reg_handler u_host_reg_handler (
        .clk            (clk),
        .resetn         (resetn),
        .reg_raddr      (reg_raddr),
        .reg_read       (reg_read),
        .reg_rdata      (reg_rdata),
        .reg_rresp      (reg_rresp),
        .reg_waddr      (reg_waddr),
        .reg_write      (reg_write),
        .reg_wresp      (reg_wresp),
        .next_slot_addr (next_slot_addr),
        .q_push         (q_push)
    );

    // Circular queue bookkeeping
    input_queue u_input_queue (
        .clk            (clk),
        .resetn         (resetn),
        .q_push         (q_push),
        .q_pop          (q_pop),
        .next_slot_addr (next_slot_addr),
        .head_addr      (head_addr),
        .q_not_empty    (q_not_empty)
    );

    //======================================================================
    // Read side, tokenize and dispatch each queued string in order
    //======================================================================
    msg_dispatch_fsm u_msg_dispatch_fsm (
        .clk              (clk),
        .resetn           (resetn),
        .q_not_empty      (q_not_empty),
        .head_addr        (head_addr),
        .q_pop            (q_pop),
        .tok_str_addr     (tok_str_addr),
        .tok_start        (tok_start),
        .tok_idle         (tok_idle),
        .dispatcher_start (dispatcher_start),
        .dispatcher_idle  (dispatcher_idle)
    );

endmodule

// ==== logic/msg_dispatch_fsm.sv ====
`timescale 1ns/10ps

module msg_dispatch_fsm
    import ipc_queue_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,

    // Queue head
    input  logic  q_not_empty,
    input  addr_t head_addr,
    output logic  q_pop,

    // Tokenizer control
    output addr_t tok_str_addr,
    output logic  tok_start,
    input  logic  tok_idle,

    // Dispatcher control
    output logic  dispatcher_start,
    input  logic  dispatcher_idle
);

    dispatch_state_t state;
    logic            start_msg;

    //======================================================================
    // Message start condition
    //======================================================================
    // q_pop lands on the next edge, so the flags seen during the pop
    // cycle still count the retired entry
    assign start_msg = (state == DS_IDLE) && q_not_empty && !q_pop;

    // String address for the tokenizer is held until the next start
    always_ff @(posedge clk) begin
        if (start_msg) begin
            tok_str_addr <= head_addr;
        end
    end

    //======================================================================
    // Dispatch FSM
    //======================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state            <= DS_IDLE;
            tok_start        <= 1'b0;
            dispatcher_start <= 1'b0;
            q_pop            <= 1'b0;
        end else begin
            // Strobes are high for one cycle only
            tok_start        <= 1'b0;
            dispatcher_start <= 1'b0;
            q_pop            <= 1'b0;

            case (state)
                DS_IDLE: begin
                    if (start_msg) begin
                        tok_start <= 1'b1;
                        state     <= DS_TOKENIZE;
                    end
                end

                // Tokenizer drops idle with its start, so waiting here
                // covers the whole tokenize run
                DS_TOKENIZE: begin
                    if (tok_idle && dispatcher_idle) begin
                        dispatcher_start <= 1'b1;
                        state            <= DS_DISPATCH;
                    end
                end

                // Message is retired once the dispatcher is done with it
                DS_DISPATCH: begin
                    if (dispatcher_idle) begin
                        q_pop <= 1'b1;
                        state <= DS_IDLE;
                    end
                end

                default: state <= DS_IDLE;
            endcase
        end
    end

    // The wait states rely on each engine dropping idle with its start
    a_tok_busy_on_start : assert property (
        @(posedge clk) disable iff (!resetn) tok_start |-> !tok_idle
    );

    a_disp_busy_on_start : assert property (
        @(posedge clk) disable iff (!resetn) dispatcher_start |-> !dispatcher_idle
    );

endmodule

// ==== logic/input_queue.sv ====
`timescale 1ns/10ps

`include "ipc_macros.svh"

module input_queue
    import ipc_queue_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,

    // One-cycle strobes from the register handler and the dispatch FSM
    input  logic  q_push,
    input  logic  q_pop,

    // Where the host should write its next string
    output addr_t next_slot_addr,

    // Oldest queued string
    output addr_t head_addr,
    output logic  q_not_empty
);

    //======================================================================
    // Indices and counts
    //======================================================================
    q_index_t windex;
    q_index_t rindex;
    q_count_t wcount;
    q_count_t rcount;
    logic     q_full;

    // Circular increment, wraps at the queue depth
    function automatic q_index_t next_index(input q_index_t idx);
        q_index_t last;
        last = q_index_t'(`IPC_Q_SIZE - 1);
        if (idx == last) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    // Slot base = RAM start + index * slot size
    function automatic addr_t slot_addr(input q_index_t idx);
        return addr_t'(`IPC_RAM_START) + (addr_t'(idx) << $clog2(`IPC_STR_MAXLEN));
    endfunction

    // Write side
    always_ff @(posedge clk) begin
        if (!resetn) begin
            windex <= '0;
            wcount <= '0;
        end else if (q_push) begin
            windex <= next_index(windex);
            wcount <= wcount + 1'b1;
        end
    end

    // Read side
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rindex <= '0;
            rcount <= '0;
        end else if (q_pop) begin
            rindex <= next_index(rindex);
            rcount <= rcount + 1'b1;
        end
    end

    //======================================================================
    // Flags and slot addresses
    //======================================================================
    assign q_full      = (wcount - rcount) == q_count_t'(`IPC_Q_SIZE);
    assign q_not_empty = (wcount != rcount);

    assign next_slot_addr = q_full ? `IPC_NO_ADDR : slot_addr(windex);
    assign head_addr      = slot_addr(rindex);

    // Dispatch FSM only pops what the host has queued
    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!resetn) q_pop |-> q_not_empty
    );

    // Host handler only pushes against a slot handed out while not full
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!resetn) q_push |-> !q_full
    );

endmodule

// ==== logic/host_reg_handler.sv ====
`timescale 1ns/10ps

`include "ipc_macros.svh"

module host_reg_handler
    import ipc_host_pkg::*;
    import ipc_queue_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,

    // One-cycle read request strobe and its response
    input  reg_data_t reg_raddr,
    input  logic      reg_read,
    output reg_data_t reg_rdata,
    output resp_t     reg_rresp,

    // One-cycle write request strobe and its response
    input  reg_data_t reg_waddr,
    input  logic      reg_write,
    output resp_t     reg_wresp,

    // Queue side
    input  addr_t     next_slot_addr,
    output logic      q_push
);

    //======================================================================
    // Address decode
    //======================================================================
    logic [6:0] rd_offset;
    logic [6:0] wr_offset;
    reg_index_t rd_index;
    reg_index_t wr_index;

    // Slot address handed to the host by the last Q_WADDR_H read
    addr_t      latched_addr;
    logic       latch_empty;

    assign rd_offset = reg_raddr[6:0] & `IPC_ADDR_MASK;
    assign wr_offset = reg_waddr[6:0] & `IPC_ADDR_MASK;

    // Registers are 32 bits wide, so drop the byte offset
    assign rd_index = reg_index_t'(rd_offset[6:2]);
    assign wr_index = reg_index_t'(wr_offset[6:2]);

    assign latch_empty = (latched_addr == `IPC_NO_ADDR);

    // Doorbell accepted only against a real latched slot
    assign q_push = reg_write && (wr_index == Q_WRITE) && !latch_empty;

    //======================================================================
    // Latch and read response
    //======================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            latched_addr <= `IPC_NO_ADDR;
            reg_rresp    <= OKAY;
        end else begin
            // An accepted doorbell consumes the latch
            // It wins over a same-cycle Q_WADDR_H read, whose address is stale
            if (q_push) begin
                latched_addr <= `IPC_NO_ADDR;
            end else if (reg_read && (rd_index == Q_WADDR_H)) begin
                latched_addr <= next_slot_addr;
            end

            if (reg_read) begin
                case (rd_index)
                    Q_WADDR_H: reg_rresp <= OKAY;
                    Q_WADDR_L: reg_rresp <= OKAY;
                    default:   reg_rresp <= DECERR;
                endcase
            end
        end
    end

    // Read data is held until the next read
    always_ff @(posedge clk) begin
        if (reg_read) begin
            case (rd_index)
                // Upper half comes straight from the queue as the latch loads it
                Q_WADDR_H: reg_rdata <= next_slot_addr[63:32];
                Q_WADDR_L: reg_rdata <= latched_addr[31:0];
                default:   reg_rdata <= '0;
            endcase
        end
    end

    //======================================================================
    // Write response
    //======================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            reg_wresp <= OKAY;
        end else if (reg_write) begin
            if (wr_index != Q_WRITE) begin
                reg_wresp <= DECERR;
            end else if (latch_empty) begin
                // No slot was handed out, or it was already used
                reg_wresp <= SLVERR;
            end else begin
                reg_wresp <= OKAY;
            end
        end
    end

    // Every push fills the slot that the latch handed out and never a full queue
    a_push_matches_slot : assert property (
        @(posedge clk) disable iff (!resetn)
        q_push |-> (latched_addr == next_slot_addr) && (next_slot_addr != `IPC_NO_ADDR)
    );

endmodule

// ==== common/ipc_queue_pkg.sv ====
`include "ipc_macros.svh"

// Types for the input queue and the dispatch side
package ipc_queue_pkg;

    //======================================================================
    // Addresses and queue bookkeeping
    //======================================================================

    // Byte address in the host RAM
    typedef logic [63:0] addr_t;

    // Slot index into the circular queue
    typedef logic [$clog2(`IPC_Q_SIZE)-1:0] q_index_t;

    // Running count of entries written or read, never wraps in practice
    typedef logic [63:0] q_count_t;

    //======================================================================
    // Dispatch FSM
    //======================================================================
    typedef enum logic [1:0] {
        // Waiting for a queued string
        DS_IDLE     = 2'd0,
        // Tokenizer started, waiting for tokenizer and dispatcher idle
        DS_TOKENIZE = 2'd1,
        // Dispatcher started, waiting for it to finish the message
        DS_DISPATCH = 2'd2
    } dispatch_state_t;

endpackage

// ==== common/ipc_host_pkg.sv ====
// Types seen by the host on the register port
package ipc_host_pkg;

    // One 32-bit register word, also used for register addresses
    typedef logic [31:0] reg_data_t;

    //======================================================================
    // Register map, index = (addr & window mask) / 4
    //======================================================================
    typedef enum logic [4:0] {
        // Read only, latches the next slot address and returns bits 63:32
        Q_WADDR_H = 5'd0,
        // Read only, bits 31:0 of the latched address
        Q_WADDR_L = 5'd1,
        // Write only, doorbell for a string written to the latched slot
        Q_WRITE   = 5'd2
    } reg_index_t;

    // Response codes, same encoding as the AXI RRESP/BRESP fields
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } resp_t;

endpackage

// ==== common/ipc_macros.svh ====
`ifndef IPC_MACROS_SVH
`define IPC_MACROS_SVH

//==========================================================================
// Host-to-FPGA message queue constants
//==========================================================================

// Base of the input-string area in RAM
`define IPC_RAM_START 64'hC000_0000

// Number of string slots in the circular queue
`define IPC_Q_SIZE 16

// Bytes per string slot, including the nul; must be a power of two
`define IPC_STR_MAXLEN 256

// Slot address meaning "no slot available"
`define IPC_NO_ADDR 64'hFFFF_FFFF_FFFF_FFFF

// Host register window, 32 registers of 32 bits
`define IPC_ADDR_MASK 7'h7F

`endif
